// File: compile.f
logic/devinfo_pkg.sv
logic/devinfo_boot_hold.sv
logic/devinfo_dna_reader.sv
logic/devinfo_icap_reader.sv
logic/devinfo_apb_regs.sv
logic/devinfo_top.sv
testbench/devinfo_prim_models.sv
testbench/devinfo_tb.sv

// File: Bender.yml
package:
  name: devinfo

sources:
  - logic/devinfo_pkg.sv
  - logic/devinfo_boot_hold.sv
  - logic/devinfo_dna_reader.sv
  - logic/devinfo_icap_reader.sv
  - logic/devinfo_apb_regs.sv
  - logic/devinfo_top.sv
  - target: test
    files:
      - testbench/devinfo_prim_models.sv
      - testbench/devinfo_tb.sv

// File: testbench/devinfo_tb.sv
`timescale 1ns/1ns

module devinfo_tb;

	import devinfo_pkg::*;

	localparam int         CLK_PERIOD     = 40;
	localparam int         DRIVE_DELAY    = 2;
	localparam int         RESET_CYCLES   = 5;
	// Cycles allowed for pready, and STATUS reads allowed while polling
	localparam int         PREADY_TIMEOUT = 8;
	localparam int         STATUS_POLLS   = 200;
	localparam icap_word_t DEV_IDCODE     = 32'h0362_D093;
	localparam apb_data_t  USERCODE_A     = 32'h5EED_0001;
	localparam apb_data_t  USERCODE_B     = 32'hA5C3_0F96;

	// One row of the access table
	typedef struct packed {
		logic      write;
		apb_addr_t addr;
		apb_data_t wdata;
		apb_data_t rdata;
		logic      err;
	} access_t;

	logic        clk_icap;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata;
	apb_data_t   prdata;
	logic        pready;
	logic        pslverr;
	apb_data_t   usercode;
	logic        dna_read;
	logic        dna_shift;
	logic        dna_dout;
	logic        icap_csib;
	logic        icap_rdwrb;
	icap_word_t  icap_i;
	icap_word_t  icap_o;
	dna_serial_t model_serial;
	logic        dna_fault;
	logic        icap_fault;
	logic        seen_sync;
	logic        seen_header;
	logic        seen_desync;

	access_t     access_table[$];

	////////////////////////////////////////////////////////////
	// DUT and primitive models

	devinfo_top devinfo_top_i (
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.clk_icap   (clk_icap),
		.reset      (reset),
		.usercode   (usercode),
		.dna_read   (dna_read),
		.dna_shift  (dna_shift),
		.dna_dout   (dna_dout),
		.icap_csib  (icap_csib),
		.icap_rdwrb (icap_rdwrb),
		.icap_i     (icap_i),
		.icap_o     (icap_o)
	);

	devinfo_dna_model dna_model_i (
		.clk_icap  (clk_icap),
		.reset     (reset),
		.dna_read  (dna_read),
		.dna_shift (dna_shift),
		.dna_dout  (dna_dout),
		.serial    (model_serial),
		.fault     (dna_fault)
	);

	devinfo_icap_model #(.IDCODE(DEV_IDCODE)) icap_model_i (
		.clk_icap    (clk_icap),
		.reset       (reset),
		.icap_csib   (icap_csib),
		.icap_rdwrb  (icap_rdwrb),
		.icap_i      (icap_i),
		.icap_o      (icap_o),
		.seen_sync   (seen_sync),
		.seen_header (seen_header),
		.seen_desync (seen_desync),
		.fault       (icap_fault)
	);

	initial begin
		clk_icap = 1'b0;
		forever #(CLK_PERIOD / 2) clk_icap = ~clk_icap;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting and compares

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_failure(input string why);
		$display("Error at %0t ns: %s", $time, why);
		abort_run();
	endtask

	task automatic check_data(input string name, input apb_data_t actual,
			input apb_data_t expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_err(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// Protocol trouble seen by either model
	always @(posedge clk_icap) begin
		if (dna_fault || icap_fault) begin
			report_failure("a primitive model saw its port driven out of protocol");
		end
	end

	////////////////////////////////////////////////////////////
	// APB requester

	// Setup, access, then wait for pready sampled mid-cycle
	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge clk_icap);
		#DRIVE_DELAY;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk_icap);
		#DRIVE_DELAY;
		penable = 1'b1;
		@(negedge clk_icap);
		while (!pready) begin
			waited++;
			if (waited > PREADY_TIMEOUT) begin
				report_failure("APB access never got pready");
			end
			@(negedge clk_icap);
		end
		rdata = prdata;
		err   = pslverr;
		// Transfer completes on this edge
		@(posedge clk_icap);
		#DRIVE_DELAY;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic add_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			input apb_data_t rdata, input logic err);
		access_t acc;
		acc = '{write, addr, wdata, rdata, err};
		access_table.push_back(acc);
	endtask

	task automatic run_access(input access_t acc);
		apb_data_t rdata;
		logic      err;
		string     name;
		name = $sformatf("%s 0x%02h", acc.write ? "write" : "read", acc.addr);
		apb_access(acc.write, acc.addr, acc.wdata, rdata, err);
		check_err({"pslverr on ", name}, err, acc.err);
		check_data({"prdata on ", name}, rdata, acc.rdata);
	endtask

	// STATUS reads 3 once both readers have finished
	task automatic wait_for_readers();
		apb_data_t status;
		logic      err;
		int        polls;
		polls  = 0;
		status = '0;
		while (status !== 32'd3) begin
			if (polls == STATUS_POLLS) begin
				report_failure("STATUS never showed both valid flags within the poll limit");
			end
			apb_access(1'b0, REG_STATUS, '0, status, err);
			check_err("pslverr on STATUS poll", err, 1'b0);
			polls++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		apb_data_t rdata;
		logic      err;
		reset    = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		usercode = USERCODE_A;
		repeat (RESET_CYCLES) @(posedge clk_icap);
		#DRIVE_DELAY;
		reset = 1'b0;

		// Pin levels out of reset
		@(negedge clk_icap);
		check_err("dna_read", dna_read, 1'b0);
		check_err("dna_shift", dna_shift, 1'b0);
		check_err("icap_csib", icap_csib, 1'b1);
		check_err("icap_rdwrb", icap_rdwrb, 1'b1);
		check_err("pready", pready, 1'b0);

		// Nothing valid yet
		apb_access(1'b0, REG_STATUS, '0, rdata, err);
		check_err("pslverr on STATUS after reset", err, 1'b0);
		check_data("prdata on STATUS after reset", rdata, '0);

		wait_for_readers();

		// Map contents against the models
		add_access(1'b0, REG_IDCODE, '0, DEV_IDCODE, 1'b0);
		add_access(1'b0, REG_SERIAL_0, '0, model_serial[95:64], 1'b0);
		add_access(1'b0, REG_SERIAL_1, '0, model_serial[63:32], 1'b0);
		add_access(1'b0, REG_SERIAL_2, '0, model_serial[31:0], 1'b0);
		add_access(1'b0, REG_USERCODE, '0, USERCODE_A, 1'b0);
		// Every mapped address refuses writes
		add_access(1'b1, REG_STATUS, 32'hFFFF_FFFF, '0, 1'b1);
		add_access(1'b1, REG_IDCODE, 32'h1234_5678, '0, 1'b1);
		add_access(1'b1, REG_SERIAL_0, 32'h0000_0000, '0, 1'b1);
		add_access(1'b1, REG_SERIAL_1, 32'hCAFE_0101, '0, 1'b1);
		add_access(1'b1, REG_SERIAL_2, 32'h8000_0001, '0, 1'b1);
		add_access(1'b1, REG_USERCODE, 32'h0F0F_F0F0, '0, 1'b1);
		// Holes and a misaligned address
		add_access(1'b0, 8'h18, '0, '0, 1'b1);
		add_access(1'b0, 8'hFC, '0, '0, 1'b1);
		add_access(1'b0, 8'h02, '0, '0, 1'b1);
		// Contents survive the refused writes
		add_access(1'b0, REG_STATUS, '0, 32'd3, 1'b0);
		add_access(1'b0, REG_IDCODE, '0, DEV_IDCODE, 1'b0);
		add_access(1'b0, REG_SERIAL_0, '0, model_serial[95:64], 1'b0);
		add_access(1'b0, REG_SERIAL_1, '0, model_serial[63:32], 1'b0);
		add_access(1'b0, REG_SERIAL_2, '0, model_serial[31:0], 1'b0);
		add_access(1'b0, REG_USERCODE, '0, USERCODE_A, 1'b0);
		foreach (access_table[n]) begin
			run_access(access_table[n]);
		end

		// Usercode follows its input
		@(posedge clk_icap);
		#DRIVE_DELAY;
		usercode = USERCODE_B;
		apb_access(1'b0, REG_USERCODE, '0, rdata, err);
		check_err("pslverr on USERCODE after change", err, 1'b0);
		check_data("prdata on USERCODE after change", rdata, USERCODE_B);

		// Whole ICAP sequence seen by the model
		if (!seen_sync) begin
			report_failure("ICAP model never saw the sync word");
		end
		if (!seen_header) begin
			report_failure("ICAP model never saw the IDCODE read header");
		end
		if (!seen_desync) begin
			report_failure("ICAP model never saw the desync followed by a deselect");
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: testbench/devinfo_prim_models.sv
`timescale 1ns/1ns

////////////////////////////////////////////////////////////
// DNA port, load on read, shift left on shift

module devinfo_dna_model (
	input  logic                     clk_icap,
	input  logic                     reset,
	input  logic                     dna_read,
	input  logic                     dna_shift,
	output logic                     dna_dout,
	output devinfo_pkg::dna_serial_t serial,
	output logic                     fault
);

	import devinfo_pkg::*;

	dna_serial_t shreg;
	// Shifts since the last load
	int          shifts;
	logic        loaded;

	// Die serial drawn once from the seeded generator
	initial begin
		void'($urandom(32'h0be7_e0f4));
		for (int w = 0; w < DNA_BITS / 32; w++) begin
			serial[w*32 +: 32] = $urandom;
		end
	end

	// MSB sits on the output pin
	assign dna_dout = shreg[DNA_BITS-1];

	always_ff @(posedge clk_icap) begin
		if (reset) begin
			shreg  <= '0;
			shifts <= 0;
			loaded <= 1'b0;
			fault  <= 1'b0;
		end else begin
			if (dna_read && dna_shift) begin
				$display("DNA model: read and shift were high in the same cycle");
				fault <= 1'b1;
			end
			if (dna_read) begin
				shreg  <= serial;
				shifts <= 0;
				loaded <= 1'b1;
			end else if (dna_shift) begin
				// More shifts than serial bits, or no load before
				if (!loaded || shifts >= DNA_BITS) begin
					$display("DNA model: shift with no loaded serial bit left to give");
					fault <= 1'b1;
				end
				shreg  <= {shreg[DNA_BITS-2:0], 1'b0};
				shifts <= shifts + 1;
			end
		end
	end

endmodule

////////////////////////////////////////////////////////////
// ICAP, command order check and IDCODE readback

module devinfo_icap_model #(
	parameter devinfo_pkg::icap_word_t IDCODE = 32'h0362_D093
) (
	input  logic                    clk_icap,
	input  logic                    reset,
	input  logic                    icap_csib,
	input  logic                    icap_rdwrb,
	input  devinfo_pkg::icap_word_t icap_i,
	output devinfo_pkg::icap_word_t icap_o,
	output logic                    seen_sync,
	output logic                    seen_header,
	output logic                    seen_desync,
	output logic                    fault
);

	import devinfo_pkg::*;

	// Where the host is in its command sequence
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SYNCED,
		PH_HEADER,
		PH_READ,
		PH_CMD,
		PH_DESYNC,
		PH_CLOSED
	} phase_t;

	phase_t     phase;
	icap_word_t word;

	// Mirror the bit order inside every byte
	function automatic icap_word_t mirror_bytes(input icap_word_t bus);
		icap_word_t plain;
		for (int i = 0; i < 32; i++) begin
			plain[i] = bus[(i & ~7) | (7 - (i & 7))];
		end
		return plain;
	endfunction

	assign word = mirror_bytes(icap_i);

	// IDCODE on the bus for the whole selected read, idle pattern else
	assign icap_o = (!icap_csib && icap_rdwrb) ? mirror_bytes(IDCODE) : '1;

	assign seen_sync   = (phase != PH_IDLE);
	assign seen_header = (phase >= PH_HEADER);
	assign seen_desync = (phase == PH_CLOSED);

	always_ff @(posedge clk_icap) begin
		if (reset) begin
			phase <= PH_IDLE;
			fault <= 1'b0;
		end else if (!icap_csib && !icap_rdwrb) begin
			case (phase)
				PH_IDLE: begin
					if (word == ICAP_SYNC) begin
						phase <= PH_SYNCED;
					end else begin
						$display("ICAP model: word %h was written before the sync word", word);
						fault <= 1'b1;
					end
				end
				PH_SYNCED: begin
					if (word == ICAP_READ_IDCODE) begin
						phase <= PH_HEADER;
					end else if (word != ICAP_NOP) begin
						$display("ICAP model: word %h came before the read header", word);
						fault <= 1'b1;
					end
				end
				// Only flushing NOPs between header and read
				PH_HEADER: begin
					if (word != ICAP_NOP) begin
						$display("ICAP model: word %h came between header and read", word);
						fault <= 1'b1;
					end
				end
				PH_READ: begin
					if (word == ICAP_WRITE_CMD) begin
						phase <= PH_CMD;
					end else if (word != ICAP_NOP) begin
						$display("ICAP model: word %h came after the read, not a CMD write", word);
						fault <= 1'b1;
					end
				end
				PH_CMD: begin
					if (word == ICAP_CMD_DESYNC) begin
						phase <= PH_DESYNC;
					end else begin
						$display("ICAP model: CMD write carried %h instead of desync", word);
						fault <= 1'b1;
					end
				end
				PH_DESYNC: begin
					if (word != ICAP_NOP) begin
						$display("ICAP model: word %h came after the desync", word);
						fault <= 1'b1;
					end
				end
				default: begin
					$display("ICAP model: word %h was written after the sequence closed", word);
					fault <= 1'b1;
				end
			endcase
		end else if (!icap_csib) begin
			// Read cycle, only legal once the header is in
			if (phase == PH_HEADER) begin
				phase <= PH_READ;
			end else if (phase != PH_READ) begin
				$display("ICAP model: read cycle out of order in the sequence");
				fault <= 1'b1;
			end
		end else if (phase == PH_DESYNC) begin
			phase <= PH_CLOSED;
		end
	end

endmodule

// File: logic/devinfo_top.sv
`timescale 1ns/1ns

module devinfo_top (
	// APB completer side
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  devinfo_pkg::apb_addr_t  paddr,
	input  devinfo_pkg::apb_data_t  pwdata,
	output devinfo_pkg::apb_data_t  prdata,
	output logic                   pready,
	output logic                   pslverr,
	// Clock, reset, user access code
	input  logic                   clk_icap,
	input  logic                   reset,
	input  devinfo_pkg::apb_data_t  usercode,
	// DNA port pins
	output logic                   dna_read,
	output logic                   dna_shift,
	input  logic                   dna_dout,
	// ICAP pins
	output logic                   icap_csib,
	output logic                   icap_rdwrb,
	output devinfo_pkg::icap_word_t icap_i,
	input  devinfo_pkg::icap_word_t icap_o
);

	import devinfo_pkg::*;

	logic        boot_done;
	dna_serial_t die_serial;
	logic        serial_valid;
	apb_data_t   idcode;
	logic        idcode_valid;

	////////////////////////////////////////////////////////////
	// Boot hold, then both readers side by side

	devinfo_boot_hold boot_hold_i (
		.clk_icap  (clk_icap),
		.reset     (reset),
		.boot_done (boot_done)
	);

	devinfo_dna_reader dna_reader_i (
		.clk_icap     (clk_icap),
		.reset        (reset),
		.boot_done    (boot_done),
		.dna_dout     (dna_dout),
		.dna_read     (dna_read),
		.dna_shift    (dna_shift),
		.die_serial   (die_serial),
		.serial_valid (serial_valid)
	);

	devinfo_icap_reader icap_reader_i (
		.clk_icap     (clk_icap),
		.reset        (reset),
		.boot_done    (boot_done),
		.icap_o       (icap_o),
		.icap_csib    (icap_csib),
		.icap_rdwrb   (icap_rdwrb),
		.icap_i       (icap_i),
		.idcode       (idcode),
		.idcode_valid (idcode_valid)
	);

	////////////////////////////////////////////////////////////
	// Register file on APB

	devinfo_apb_regs apb_regs_i (
		.clk_icap     (clk_icap),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.die_serial   (die_serial),
		.serial_valid (serial_valid),
		.idcode       (idcode),
		.idcode_valid (idcode_valid),
		.usercode     (usercode)
	);

endmodule

// File: logic/devinfo_apb_regs.sv
`timescale 1ns/1ns

module devinfo_apb_regs (
	input  logic                    clk_icap,
	input  logic                    reset,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  devinfo_pkg::apb_addr_t   paddr,
	input  devinfo_pkg::apb_data_t   pwdata,
	output devinfo_pkg::apb_data_t   prdata,
	output logic                    pready,
	output logic                    pslverr,
	input  devinfo_pkg::dna_serial_t die_serial,
	input  logic                    serial_valid,
	input  devinfo_pkg::apb_data_t   idcode,
	input  logic                    idcode_valid,
	input  devinfo_pkg::apb_data_t   usercode
);

	import devinfo_pkg::*;

	////////////////////////////////////////////////////////////
	// Readback

	// Zero wait states, data only in the access phase
	always_comb begin
		pready  = psel && penable;
		prdata  = '0;
		pslverr = 1'b0;
		if (pready) begin
			// Nothing is writable
			if (pwrite) begin
				pslverr = 1'b1;
			end else begin
				case (paddr)
					REG_STATUS:   prdata = {30'd0, serial_valid, idcode_valid};
					REG_IDCODE:   prdata = idcode;
					REG_SERIAL_0: prdata = die_serial[95:64];
					REG_SERIAL_1: prdata = die_serial[63:32];
					REG_SERIAL_2: prdata = die_serial[31:0];
					REG_USERCODE: prdata = usercode;
					// Hole in the map
					default:      pslverr = 1'b1;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Error only on a completing transfer
	pslverr_needs_pready: assert property (
		@(posedge clk_icap) disable iff (reset)
		pslverr |-> pready
	);

	// Requester holds the transfer steady from setup into access
	apb_setup_stable: assert property (
		@(posedge clk_icap) disable iff (reset)
		psel && !penable |=> penable && $stable({pwrite, paddr, pwdata})
	);

endmodule

// File: logic/devinfo_icap_reader.sv
`timescale 1ns/1ns

module devinfo_icap_reader (
	input  logic                   clk_icap,
	input  logic                   reset,
	input  logic                   boot_done,
	input  devinfo_pkg::icap_word_t icap_o,
	output logic                   icap_csib,
	output logic                   icap_rdwrb,
	output devinfo_pkg::icap_word_t icap_i,
	output devinfo_pkg::apb_data_t  idcode,
	output logic                   idcode_valid
);

	import devinfo_pkg::*;

	typedef enum logic [2:0] {
		ST_BOOT_HOLD,
		ST_SYNC,
		ST_NOP,
		ST_HEADER,
		ST_PIPE,
		ST_READ,
		ST_DESYNC
	} state_t;

	state_t     state;
	// Cycle count within a state
	logic [2:0] step;
	// Outgoing word before the bit reversal
	icap_word_t icap_din;

	////////////////////////////////////////////////////////////
	// Bus bit order

	// ICAP bus has each byte bit-reversed, both directions
	function automatic icap_word_t byte_bit_swap(input icap_word_t word);
		icap_word_t swapped;
		for (int b = 0; b < 4; b++) begin
			for (int g = 0; g < 8; g++) begin
				swapped[b*8 + g] = word[b*8 + 7 - g];
			end
		end
		return swapped;
	endfunction

	assign icap_i = byte_bit_swap(icap_din);

	////////////////////////////////////////////////////////////
	// Command sequence

	// RDWRB only moves with CSIB high on both sides of the edge
	always_ff @(posedge clk_icap) begin
		if (reset) begin
			state        <= ST_BOOT_HOLD;
			step         <= '0;
			icap_csib    <= 1'b1;
			icap_rdwrb   <= 1'b1;
			// Idle bus pattern
			icap_din     <= '1;
			idcode_valid <= 1'b0;
		end else begin
			case (state)
				// Switch to write while still deselected
				ST_BOOT_HOLD: begin
					if (boot_done) begin
						icap_rdwrb <= 1'b0;
						state      <= ST_SYNC;
					end
				end
				ST_SYNC: begin
					icap_csib <= 1'b0;
					icap_din  <= ICAP_SYNC;
					step      <= '0;
					state     <= ST_NOP;
				end
				// Two NOPs cover the hazard after sync
				ST_NOP: begin
					icap_din <= ICAP_NOP;
					step     <= step + 3'd1;
					if (step == 3'd1) begin
						step  <= '0;
						state <= ST_HEADER;
					end
				end
				ST_HEADER: begin
					icap_din <= ICAP_READ_IDCODE;
					state    <= ST_PIPE;
				end
				// Flush NOPs, then turn the bus around to read
				ST_PIPE: begin
					icap_din <= ICAP_NOP;
					step     <= step + 3'd1;
					if (step == 3'd2) begin
						icap_csib <= 1'b1;
					end
					if (step == 3'd3) begin
						icap_rdwrb <= 1'b1;
					end
					if (step == 3'd4) begin
						icap_csib <= 1'b0;
						step      <= '0;
						state     <= ST_READ;
					end
				end
				// Fixed read window
				ST_READ: begin
					step <= step + 3'd1;
					if (step == 3'd5) begin
						icap_csib <= 1'b1;
						step      <= '0;
						state     <= ST_DESYNC;
					end
				end
				// Back to write, send the desync, then park
				ST_DESYNC: begin
					if (step != 3'd6) begin
						step <= step + 3'd1;
					end
					case (step)
						3'd0: icap_rdwrb <= 1'b0;
						3'd1: begin
							icap_csib <= 1'b0;
							icap_din  <= ICAP_NOP;
						end
						3'd2: icap_din <= ICAP_WRITE_CMD;
						3'd3: icap_din <= ICAP_CMD_DESYNC;
						3'd4: icap_din <= ICAP_NOP;
						// Sequence over, IDCODE already held
						3'd5: begin
							icap_csib    <= 1'b1;
							idcode_valid <= 1'b1;
						end
						default: ;
					endcase
				end
				default: state <= ST_BOOT_HOLD;
			endcase
		end
	end

	// Read data settled by the fourth window cycle
	always_ff @(posedge clk_icap) begin
		if (state == ST_READ && step == 3'd3) begin
			idcode <= byte_bit_swap(icap_o);
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Direction never flips while selected
	rdwrb_while_deselected: assert property (
		@(posedge clk_icap) disable iff (reset)
		$changed(icap_rdwrb) |-> $past(icap_csib) && icap_csib
	);

endmodule

// File: logic/devinfo_dna_reader.sv
`timescale 1ns/1ns

module devinfo_dna_reader (
	input  logic                    clk_icap,
	input  logic                    reset,
	input  logic                    boot_done,
	input  logic                    dna_dout,
	output logic                    dna_read,
	output logic                    dna_shift,
	output devinfo_pkg::dna_serial_t die_serial,
	output logic                    serial_valid
);

	import devinfo_pkg::*;

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_SHIFT,
		ST_DONE
	} state_t;

	state_t                 state;
	// Bits already taken in
	logic [DNA_CNT_W-1:0]   bit_count;

	////////////////////////////////////////////////////////////
	// Read FSM

	always_ff @(posedge clk_icap) begin
		if (reset) begin
			state        <= ST_WAIT;
			bit_count    <= '0;
			dna_read     <= 1'b0;
			dna_shift    <= 1'b0;
			serial_valid <= 1'b0;
		end else begin
			case (state)
				// Single cycle load of the port shift register
				ST_WAIT: begin
					if (boot_done) begin
						dna_read <= 1'b1;
						state    <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					dna_read  <= 1'b0;
					dna_shift <= 1'b1;
					// A bit lands on every edge with shift high
					if (dna_shift) begin
						bit_count <= bit_count + 1'b1;
						if (bit_count == DNA_CNT_W'(DNA_BITS - 1)) begin
							dna_shift    <= 1'b0;
							serial_valid <= 1'b1;
							state        <= ST_DONE;
						end
					end
				end
				// Idle until reset
				ST_DONE: begin
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	// Port output is sampled before the shift moves it, MSB first
	always_ff @(posedge clk_icap) begin
		if (state == ST_SHIFT && dna_shift) begin
			die_serial <= {die_serial[DNA_BITS-2:0], dna_dout};
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Load and shift are exclusive on the port
	dna_read_shift_excl: assert property (
		@(posedge clk_icap) disable iff (reset)
		!(dna_read && dna_shift)
	);

endmodule

// File: logic/devinfo_boot_hold.sv
`timescale 1ns/1ns

module devinfo_boot_hold (
	input  logic clk_icap,
	input  logic reset,
	output logic boot_done
);

	import devinfo_pkg::*;

	////////////////////////////////////////////////////////////
	// Settle timer

	// Counts down from the hold length, parks at zero
	logic [BOOT_CNT_W-1:0] count;

	always_ff @(posedge clk_icap) begin
		if (reset) begin
			count     <= BOOT_CNT_W'(BOOT_HOLD_CYCLES);
			boot_done <= 1'b0;
		end else begin
			if (count != '0) begin
				count <= count - 1'b1;
			end
			// Flag goes up on the edge the count hits zero
			if (count == BOOT_CNT_W'(1)) begin
				boot_done <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// Sticky until the next reset
	boot_done_sticky: assert property (
		@(posedge clk_icap) disable iff (reset)
		boot_done |=> boot_done
	);

endmodule

// File: logic/devinfo_pkg.sv
package devinfo_pkg;

	////////////////////////////////////////////////////////////
	// Sizes and timing

	// Cycles to wait after reset before the ports are touched
	localparam int BOOT_HOLD_CYCLES = 64;
	localparam int BOOT_CNT_W = $clog2(BOOT_HOLD_CYCLES + 1);

	// Die serial length and its bit counter width
	localparam int DNA_BITS = 96;
	localparam int DNA_CNT_W = $clog2(DNA_BITS);

	////////////////////////////////////////////////////////////
	// Bus and payload types

	// APB byte address
	typedef logic [7:0] apb_addr_t;

	// APB data word
	typedef logic [31:0] apb_data_t;

	// Die serial, bit 95 arrives first
	typedef logic [DNA_BITS-1:0] dna_serial_t;

	// One word on the ICAP data bus
	typedef logic [31:0] icap_word_t;

	// Register map, byte addresses
	typedef enum logic [7:0] {
		// Bit 0 IDCODE valid, bit 1 serial valid
		REG_STATUS   = 8'h00,
		REG_IDCODE   = 8'h04,
		// Serial bits 95:64
		REG_SERIAL_0 = 8'h08,
		// Serial bits 63:32
		REG_SERIAL_1 = 8'h0C,
		// Serial bits 31:0
		REG_SERIAL_2 = 8'h10,
		REG_USERCODE = 8'h14
	} reg_id_t;

	////////////////////////////////////////////////////////////
	// ICAP command words

	localparam icap_word_t ICAP_SYNC        = 32'hAA995566;
	localparam icap_word_t ICAP_NOP         = 32'h20000000;
	// Type 1 read, IDCODE register, one word
	localparam icap_word_t ICAP_READ_IDCODE = 32'h28018001;
	// Type 1 write, CMD register, one word
	localparam icap_word_t ICAP_WRITE_CMD   = 32'h30008001;
	localparam icap_word_t ICAP_CMD_DESYNC  = 32'h0000000D;

endpackage
